// File: sources.f
hdl/xc_pkg.sv
hdl/line_sampler.sv
hdl/correlator.sv
hdl/frame_packer.sv
hdl/uart_tx.sv
hdl/xc_top.sv
dv/xc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the correlator testbench with Verilator and runs it once from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module xc_tb -o xc_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/xc_sim | tee /dev/stderr | grep -F -q "RESULT: PASS" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }

// File: dv/xc_tb.sv
// line_in only changes right after a sample tick, so every period counts one known vector
// stops at the first mismatch; twelve frames of 4 lines with CLK_DIV 8 and BAUD_DIV 4
`timescale 1ns/1ps

module xc_tb;

	localparam int NUM_LINES   = 4;
	localparam int CLK_DIV     = 8;
	localparam int BAUD_DIV    = 4;
	localparam int NUM_PAIRS   = xc_pkg::num_pairs(NUM_LINES);
	localparam int NUM_WORDS   = 1 + NUM_LINES + NUM_PAIRS;
	localparam int FRAME_BYTES = NUM_WORDS * xc_pkg::WORD_BYTES;
	localparam int NUM_FRAMES  = 12;
	localparam int MAX_GAP     = 40; // most ticks between two strobes
	// each frame takes its bytes on the line plus the longest strobe gap, then twice that
	localparam int LIMIT_CYCLES =
		2 * NUM_FRAMES * (FRAME_BYTES * 10 * BAUD_DIV + MAX_GAP * CLK_DIV);

	logic                 sysclk;
	logic                 arst_n;
	logic [NUM_LINES-1:0] line_in;
	logic                 strobe;
	logic                 sample_tick;
	logic                 busy;
	logic                 tx;

	integer               seed;             // shared by every $random call
	xc_pkg::count_t       auto_cnt  [NUM_LINES];
	xc_pkg::count_t       cross_cnt [NUM_PAIRS];
	logic [NUM_LINES-1:0] pending;          // vector that the next tick will count
	int                   ticks_left;       // ticks until the next strobe goes out
	int                   frames_accepted;
	int                   ignored_strobes;
	int                   since_tick;       // edges since the last tick seen
	xc_pkg::header_t      exp_hdr    [$];
	xc_pkg::count_t       exp_counts [$];
	string                exp_names  [$];   // test name for each expected count

	xc_top #(
		.NUM_LINES (NUM_LINES),
		.CLK_DIV   (CLK_DIV),
		.BAUD_DIV  (BAUD_DIV)
	) i_xc_top (
		.sysclk      (sysclk),
		.arst_n      (arst_n),
		.line_in     (line_in),
		.strobe      (strobe),
		.sample_tick (sample_tick),
		.busy        (busy),
		.tx          (tx)
	);

	always #2 sysclk = ~sysclk; // 4 ns period

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_count(input string name, input xc_pkg::count_t exp,
		input xc_pkg::count_t act);
		if (act !== exp) begin
			$display("ERROR %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_header(input string name, input xc_pkg::header_t exp,
		input xc_pkg::header_t act);
		if (act !== exp) begin
			$display("ERROR %s expected sync %h seq %0d lines %0d actual sync %h seq %0d lines %0d",
				name, exp.sync, exp.seq, exp.lines, act.sync, act.seq, act.lines);
			abort_run();
		end
	endtask

	// gap of 1 to MAX_GAP ticks before the next strobe
	function automatic int random_gap();
		logic [31:0] r;
		r = $random(seed);
		return 1 + int'(r % 32'(MAX_GAP));
	endfunction

	// lag zero correlation of one sampled vector
	task automatic count_sample(input logic [NUM_LINES-1:0] s);
		int p;
		p = 0;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (s[i]) auto_cnt[i] = auto_cnt[i] + 1'b1;
		end
		for (int i = 0; i < NUM_LINES; i++) begin
			for (int j = i + 1; j < NUM_LINES; j++) begin
				if (s[i] && s[j]) cross_cnt[p] = cross_cnt[p] + 1'b1; // both lines high
				p++;
			end
		end
	endtask

	// an accepted strobe freezes the frame that will come out and restarts counting
	task automatic take_snapshot();
		xc_pkg::header_t hdr;
		int              p;
		hdr.sync  = xc_pkg::SYNC_BYTE;
		hdr.seq   = 8'(frames_accepted);
		hdr.lines = 8'(NUM_LINES);
		exp_hdr.push_back(hdr);
		for (int i = 0; i < NUM_LINES; i++) begin
			exp_counts.push_back(auto_cnt[i]);
			exp_names.push_back($sformatf("frame %0d auto line %0d", frames_accepted, i));
			auto_cnt[i] = '0;
		end
		p = 0;
		for (int i = 0; i < NUM_LINES; i++) begin
			for (int j = i + 1; j < NUM_LINES; j++) begin
				exp_counts.push_back(cross_cnt[p]);
				exp_names.push_back($sformatf("frame %0d cross %0d-%0d", frames_accepted, i, j));
				cross_cnt[p] = '0;
				p++;
			end
		end
		frames_accepted++;
	endtask

	// waits for a start bit and samples each bit near its middle
	task automatic receive_byte(output logic [7:0] data);
		do @(posedge sysclk); while (tx !== 1'b0);
		repeat (BAUD_DIV / 2) @(posedge sysclk);
		if (tx !== 1'b0) begin
			$display("start bit on tx was shorter than half a bit time");
			abort_run();
		end
		for (int k = 0; k < 8; k++) begin
			repeat (BAUD_DIV) @(posedge sysclk);
			data[k] = tx; // lsb first
		end
		repeat (BAUD_DIV) @(posedge sysclk);
		if (tx !== 1'b1) begin
			$display("stop bit missing on tx");
			abort_run();
		end
	endtask

	task automatic receive_word(output xc_pkg::frame_word_u word);
		logic [7:0] b;
		for (int k = 0; k < xc_pkg::WORD_BYTES; k++) begin
			receive_byte(b);
			word.count[k * 8 +: 8] = b; // first byte is the low one
		end
	endtask

	// stimulus and model, all DUT outputs read here hold their pre edge value
	always @(posedge sysclk) begin
		if (arst_n) begin
			strobe <= 1'b0; // strobe is a one cycle pulse
			if (sample_tick) begin
				count_sample(pending);
				pending = NUM_LINES'($random(seed));
				line_in <= pending; // held until the next tick counts it
				if (ticks_left == 1) begin
					strobe <= 1'b1;
					ticks_left = random_gap();
				end else begin
					ticks_left--;
				end
			end
			if (strobe && !busy) begin
				take_snapshot();
			end else if (strobe) begin
				ignored_strobes++; // frame still going out, counts keep growing
			end
		end
	end

	// tick spacing and idle outputs before the first frame
	always @(posedge sysclk) begin
		if (arst_n) begin
			if (sample_tick) begin
				check_count("tick period", xc_pkg::count_t'(CLK_DIV),
					xc_pkg::count_t'(since_tick));
				since_tick = 1;
			end else begin
				since_tick++;
			end
			if (frames_accepted == 0 && (tx !== 1'b1 || busy !== 1'b0)) begin
				$display("tx or busy left idle before the first strobe was accepted");
				abort_run();
			end
		end
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge sysclk);
		$display("timeout after %0d cycles with fewer than %0d frames decoded",
			LIMIT_CYCLES, NUM_FRAMES);
		abort_run();
	end

	initial begin
		xc_pkg::frame_word_u word;
		sysclk  = 1'b0;
		arst_n  = 1'b0;
		line_in = '0;
		strobe  = 1'b0;
		seed    = 32'hcf7965c0;
		for (int i = 0; i < NUM_LINES; i++) auto_cnt[i] = '0;
		for (int p = 0; p < NUM_PAIRS; p++) cross_cnt[p] = '0;
		pending         = '0; // the first tick sees the lines still at zero
		ticks_left      = random_gap();
		frames_accepted = 0;
		ignored_strobes = 0;
		since_tick      = 0;  // release edge counts as zero
		repeat (10) @(posedge sysclk);
		arst_n <= 1'b1;

		// frames follow each other with no bytes in between, so word 0 is always a header
		for (int f = 0; f < NUM_FRAMES; f++) begin
			receive_word(word);
			if (exp_hdr.size() == 0) begin
				$display("a frame came out of the UART with no accepted strobe behind it");
				abort_run();
			end
			check_header($sformatf("frame %0d header", f), exp_hdr.pop_front(), word.hdr);
			for (int w = 1; w < NUM_WORDS; w++) begin
				receive_word(word);
				check_count(exp_names.pop_front(), exp_counts.pop_front(), word.count);
			end
		end

		if (ignored_strobes > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("no strobe arrived while a frame was going out, so dropping went untested");
			abort_run();
		end
	end

endmodule

// File: hdl/xc_top.sv
// plain ports, no pin mapping; line_in is sampled every CLK_DIV cycles (CLK_DIV >= 4)
// a frame is one header word plus all counts, three bytes per word over the UART
`timescale 1ns/1ps

module xc_top #(
	parameter int NUM_LINES = 4,
	parameter int CLK_DIV   = 8,
	parameter int BAUD_DIV  = 4
) (
	input  logic                 sysclk,
	input  logic                 arst_n,
	input  logic [NUM_LINES-1:0] line_in,
	input  logic                 strobe,
	output logic                 sample_tick, // one pulse per sampling instant
	output logic                 busy,        // frame on the way out
	output logic                 tx
);

	localparam int NUM_WORDS = 1 + NUM_LINES + xc_pkg::num_pairs(NUM_LINES);

	logic [NUM_LINES-1:0]                    sample;
	logic                                    frame_start;
	logic [NUM_WORDS*xc_pkg::COUNT_BITS-1:0] snap_words;
	logic                                    tx_start;
	logic [7:0]                              tx_byte;
	logic                                    tx_busy;

	// sample_tick doubles as the sample valid pulse into the correlator
	line_sampler #(
		.NUM_LINES (NUM_LINES),
		.CLK_DIV   (CLK_DIV)
	) i_line_sampler (
		.sysclk       (sysclk),
		.arst_n       (arst_n),
		.line_in      (line_in),
		.sample_valid (sample_tick),
		.sample       (sample)
	);

	correlator #(
		.NUM_LINES (NUM_LINES)
	) i_correlator (
		.sysclk       (sysclk),
		.arst_n       (arst_n),
		.sample_valid (sample_tick),
		.sample       (sample),
		.strobe       (strobe),
		.busy         (busy),
		.frame_start  (frame_start),
		.snap_words   (snap_words)
	);

	frame_packer #(
		.NUM_LINES (NUM_LINES)
	) i_frame_packer (
		.sysclk      (sysclk),
		.arst_n      (arst_n),
		.frame_start (frame_start),
		.snap_words  (snap_words),
		.tx_busy     (tx_busy),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.busy        (busy)
	);

	uart_tx #(
		.BAUD_DIV (BAUD_DIV)
	) i_uart_tx (
		.sysclk   (sysclk),
		.arst_n   (arst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.tx       (tx)
	);

endmodule

// File: hdl/uart_tx.sv
// 8N1 only, one bit lasts BAUD_DIV sysclk cycles
// tx_start is ignored while tx_busy is high
`timescale 1ns/1ps

module uart_tx #(
	parameter int BAUD_DIV = 4
) (
	input  logic       sysclk,
	input  logic       arst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy,
	output logic       tx
);

	localparam int BAUD_BITS = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [BAUD_BITS-1:0] BAUD_LOAD = BAUD_BITS'(BAUD_DIV - 1);

	logic [9:0]           shreg;    // stop, data msb..lsb, start
	logic [BAUD_BITS-1:0] baud_cnt; // cycles left in the current bit
	logic [3:0]           bit_cnt;  // bits still to shift out after this one

	// ones shift in from the top, so the line rests high between bytes
	assign tx = shreg[0];

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			shreg    <= '1;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			tx_busy  <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				shreg    <= {1'b1, tx_byte, 1'b0};
				baud_cnt <= BAUD_LOAD;
				bit_cnt  <= 4'd9;
				tx_busy  <= 1'b1;
			end
		end else if (baud_cnt != '0) begin
			baud_cnt <= baud_cnt - 1'b1;
		end else if (bit_cnt != '0) begin
			shreg    <= {1'b1, shreg[9:1]}; // next bit onto the line
			bit_cnt  <= bit_cnt - 4'd1;
			baud_cnt <= BAUD_LOAD;
		end else begin
			tx_busy <= 1'b0; // stop bit has run its full length
		end
	end

endmodule

// File: hdl/frame_packer.sv
// snap_words must stay stable while busy is high, which the correlator guarantees
// busy falls only after the stop bit of the last byte has ended
`timescale 1ns/1ps

module frame_packer #(
	parameter  int NUM_LINES = 4,
	localparam int NUM_WORDS = 1 + NUM_LINES + xc_pkg::num_pairs(NUM_LINES)
) (
	input  logic                                    sysclk,
	input  logic                                    arst_n,
	input  logic                                    frame_start,
	input  logic [NUM_WORDS*xc_pkg::COUNT_BITS-1:0] snap_words,
	input  logic                                    tx_busy,
	output logic                                    tx_start,
	output logic [7:0]                              tx_byte,
	output logic                                    busy
);

	localparam int WORD_BITS = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
	localparam int BYTE_BITS = $clog2(xc_pkg::WORD_BYTES);
	localparam logic [WORD_BITS-1:0] LAST_WORD = WORD_BITS'(NUM_WORDS - 1);
	localparam logic [BYTE_BITS-1:0] LAST_BYTE = BYTE_BITS'(xc_pkg::WORD_BYTES - 1);

	logic [WORD_BITS-1:0] word_idx;  // word being sent, 0 is the header
	logic [BYTE_BITS-1:0] byte_idx;  // byte within that word, lsb first
	logic                 last_sent; // final byte handed over, waiting for its stop bit
	logic                 can_issue;
	xc_pkg::frame_word_u  cur_word;
	logic [7:0]           cur_byte;

	assign cur_word = snap_words[word_idx * xc_pkg::COUNT_BITS +: xc_pkg::COUNT_BITS];

	// tx_start is checked too, the UART raises tx_busy one cycle after the pulse
	assign can_issue = busy && !last_sent && !tx_busy && !tx_start;

	// the header goes out by byte lane like a count since sync sits in the low lane
	assign cur_byte = cur_word.count[byte_idx * 8 +: 8];

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			word_idx  <= '0;
			byte_idx  <= '0;
			last_sent <= 1'b0;
			tx_start  <= 1'b0;
		end else begin
			tx_start <= can_issue;
			if (frame_start) begin
				busy      <= 1'b1;
				word_idx  <= '0;
				byte_idx  <= '0;
				last_sent <= 1'b0;
			end else if (can_issue) begin
				if (byte_idx == LAST_BYTE) begin
					byte_idx <= '0;
					if (word_idx == LAST_WORD) begin
						last_sent <= 1'b1;
					end else begin
						word_idx <= word_idx + 1'b1;
					end
				end else begin
					byte_idx <= byte_idx + 1'b1;
				end
			end else if (last_sent && !tx_busy && !tx_start) begin
				busy      <= 1'b0; // line is idle again, frame done
				last_sent <= 1'b0;
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (can_issue) begin
			tx_byte <= cur_byte;
		end
	end

	// the UART drops a start pulse while it is busy, so one would lose a byte
	a_start_uart_idle: assert property (
		@(posedge sysclk) disable iff (!arst_n)
		tx_start |-> !tx_busy
	);

endmodule

// File: hdl/correlator.sv
// lag zero only, counters wrap modulo 2^COUNT_BITS and NUM_LINES must be at least 2
// a strobe is dropped while busy is high or while frame_start is still out
`timescale 1ns/1ps

module correlator #(
	parameter  int NUM_LINES = 4,
	localparam int NUM_WORDS = 1 + NUM_LINES + xc_pkg::num_pairs(NUM_LINES)
) (
	input  logic                                    sysclk,
	input  logic                                    arst_n,
	input  logic                                    sample_valid,
	input  logic [NUM_LINES-1:0]                    sample,
	input  logic                                    strobe,
	input  logic                                    busy,
	output logic                                    frame_start,
	output logic [NUM_WORDS*xc_pkg::COUNT_BITS-1:0] snap_words
);

	localparam int NUM_PAIRS = xc_pkg::num_pairs(NUM_LINES);
	localparam int CB        = xc_pkg::COUNT_BITS;

	xc_pkg::count_t  auto_cnt   [NUM_LINES]; // live counts, one per line
	xc_pkg::count_t  auto_next  [NUM_LINES]; // live count plus this cycle's sample
	xc_pkg::count_t  cross_cnt  [NUM_PAIRS]; // live counts, one per pair
	xc_pkg::count_t  cross_next [NUM_PAIRS];
	logic [7:0]      seq_num;                // number of the next frame
	logic            accept;                 // strobe taken this cycle
	xc_pkg::header_t hdr;

	// frame_start is checked too, busy only rises one cycle after it
	assign accept = strobe && !busy && !frame_start;

	assign hdr.sync  = xc_pkg::SYNC_BYTE;
	assign hdr.seq   = seq_num;
	assign hdr.lines = 8'(NUM_LINES);

	// every line adds one when it is high in a valid sample
	for (genvar i = 0; i < NUM_LINES; i++) begin : g_auto
		assign auto_next[i] = auto_cnt[i] + xc_pkg::count_t'(sample_valid & sample[i]);
	end

	// pairs are numbered (0,1), (0,2) .. (1,2) .. which matches the frame order
	for (genvar i = 0; i < NUM_LINES; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_LINES; j++) begin : g_col
			localparam int P = i * (2 * NUM_LINES - i - 1) / 2 + (j - i - 1);
			assign cross_next[P] = cross_cnt[P]
				+ xc_pkg::count_t'(sample_valid & sample[i] & sample[j]);
		end
	end

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				auto_cnt[i] <= '0;
			end
			for (int p = 0; p < NUM_PAIRS; p++) begin
				cross_cnt[p] <= '0;
			end
			seq_num     <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= accept; // packer starts one cycle after the snapshot
			if (accept) begin
				seq_num <= seq_num + 8'd1; // wraps after 255 frames
			end
			// an accepted strobe restarts counting from zero
			for (int i = 0; i < NUM_LINES; i++) begin
				auto_cnt[i] <= accept ? '0 : auto_next[i];
			end
			for (int p = 0; p < NUM_PAIRS; p++) begin
				cross_cnt[p] <= accept ? '0 : cross_next[p];
			end
		end
	end

	// the snapshot holds the counts including a sample that lands with the strobe
	always_ff @(posedge sysclk) begin
		if (accept) begin
			snap_words[0 +: CB] <= hdr; // header word goes first
			for (int i = 0; i < NUM_LINES; i++) begin
				snap_words[(1 + i) * CB +: CB] <= auto_next[i];
			end
			for (int p = 0; p < NUM_PAIRS; p++) begin
				snap_words[(1 + NUM_LINES + p) * CB +: CB] <= cross_next[p];
			end
		end
	end

	// a new frame while the packer still sends the last one would tear the snapshot
	a_start_idle: assert property (
		@(posedge sysclk) disable iff (!arst_n)
		frame_start |-> !busy
	);

endmodule

// File: hdl/line_sampler.sv
// line_in is asynchronous and goes through two flops, so CLK_DIV must be at least 4
// first sample_valid comes CLK_DIV cycles after reset release, then one every CLK_DIV
`timescale 1ns/1ps

module line_sampler #(
	parameter int NUM_LINES = 4,
	parameter int CLK_DIV   = 8
) (
	input  logic                 sysclk,
	input  logic                 arst_n,
	input  logic [NUM_LINES-1:0] line_in,
	output logic                 sample_valid,
	output logic [NUM_LINES-1:0] sample
);

	localparam int DIV_BITS = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DIV_BITS-1:0] DIV_LOAD = DIV_BITS'(CLK_DIV - 1);

	logic [NUM_LINES-1:0] sync1;   // first stage, may go metastable
	logic [NUM_LINES-1:0] sync2;   // settled copy of line_in
	logic [DIV_BITS-1:0]  div_cnt; // counts down the sample period
	logic                 smp_now; // last cycle of the period

	assign smp_now = (div_cnt == '0);

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			sync1        <= '0;
			sync2        <= '0;
			div_cnt      <= DIV_LOAD; // so the first tick lands CLK_DIV cycles out
			sample_valid <= 1'b0;
		end else begin
			sync1        <= line_in;
			sync2        <= sync1;
			sample_valid <= smp_now; // tick rides along with the sample register
			if (smp_now) begin
				div_cnt <= DIV_LOAD;
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	// the sampled vector only changes with a tick and is read only with one
	always_ff @(posedge sysclk) begin
		if (smp_now) begin
			sample <= sync2;
		end
	end

	// the correlator treats each pulse as exactly one sample, back to back pulses
	// would mean the divider collapsed to a single cycle
	a_tick_single: assert property (
		@(posedge sysclk) disable iff (!arst_n)
		sample_valid |=> !sample_valid
	);

endmodule

// File: hdl/xc_pkg.sv
// frame word layout is fixed at 24 bits, so the header and a count share one word
// header bytes go out sync first because sync sits in the low byte
package xc_pkg;

	// width of every live counter, snapshot count and frame word
	localparam int COUNT_BITS = 24;

	// a frame word leaves the UART as this many bytes, least significant first
	localparam int WORD_BYTES = COUNT_BITS / 8;

	// marker in the first byte of every frame
	localparam logic [7:0] SYNC_BYTE = 8'hA5;

	// unsigned count that simply wraps
	typedef logic [COUNT_BITS-1:0] count_t;

	// header word, declared msb first so that sync lands in bits 7:0
	typedef struct packed {
		logic [7:0] lines; // number of input lines in this build
		logic [7:0] seq;   // frame sequence number, 0 after reset
		logic [7:0] sync;  // always SYNC_BYTE
	} header_t;

	// word 0 of a frame reads as a header and every later word as a count
	typedef union packed {
		count_t  count;
		header_t hdr;
	} frame_word_u;

	// number of distinct line pairs, one cross counter each
	function automatic int num_pairs(input int n);
		int pairs;
		pairs = n * (n - 1) / 2;
		return pairs;
	endfunction

endpackage
